/* common/regroup_pkg.sv */
package regroup_pkg;

   //////////////////////////////////////////////////
   // widths and depth
   //////////////////////////////////////////////////

   // one lane data word
   localparam int word_w = 64;

   // ring addressing, in words
   localparam int addr_w = 6;
   localparam int depth  = 64;

   // an output beat carries two words, word 1 in the upper half
   localparam int beat_data_w = 2 * word_w;

   //////////////////////////////////////////////////
   // plain vector types
   //////////////////////////////////////////////////

   typedef logic [word_w-1:0] data_word_t;

   // ring address, wraps modulo depth
   typedef logic [addr_w-1:0] addr_t;

   // words per cycle, 0 to 2
   typedef logic [1:0] num_t;

   // end of packet code
   // 0000 no eop
   // 1nnn eop with nnn valid bytes, 000 meaning 8
   // 0001 and any other 0xxx is an errored eop
   typedef logic [3:0] eop_code_t;

   //////////////////////////////////////////////////
   // grouped signals
   //////////////////////////////////////////////////

   // one ring entry, 69 bits
   typedef struct packed {
      logic       sop;
      eop_code_t  eop_code;
      data_word_t data;
   } tag_word_t;

   // inbound group, valid words packed toward w1
   typedef struct packed {
      tag_word_t w1;
      tag_word_t w0;
      num_t      num;
   } in_grp_t;

   // streaming-bus output beat
   typedef struct packed {
      logic [beat_data_w-1:0] data;
      logic                   sop;
      logic                   eop;
      logic [3:0]             empty;
      logic                   error;
   } beat_t;

   // read scheduler wait state
   typedef enum logic {
      idle,
      hold_single
   } sched_state_t;

endpackage

/* regroup/regroup_wr_ctrl.sv */
module regroup_wr_ctrl (
   input  logic                           clk,
   input  logic                           arst,
   input  regroup_pkg::in_grp_t           in_grp,
   output regroup_pkg::tag_word_t [1:0]   wr_words,
   output regroup_pkg::num_t              wr_num,
   output regroup_pkg::addr_t             wr_addr,
   output logic [1:0]                     eop_mark
);

   //////////////////////////////////////////////////
   // input group register
   //////////////////////////////////////////////////

   // payload, index 1 is the first word
   always_ff @(posedge clk) begin
      wr_words[1] <= in_grp.w1;
      wr_words[0] <= in_grp.w0;
   end

   // word count of the registered group
   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         wr_num <= '0;
      end
      else begin
         wr_num <= in_grp.num;
      end
   end

   //////////////////////////////////////////////////
   // write pointer
   //////////////////////////////////////////////////

   // moves by the words just written
   // 6 bit sum wraps at the ring end on its own
   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         wr_addr <= '0;
      end
      else begin
         wr_addr <= wr_addr + wr_num;
      end
   end

   //////////////////////////////////////////////////
   // per word eop marks
   //////////////////////////////////////////////////

   // any nonzero code ends a packet, errored or not
   // only words covered by wr_num are marked
   always_comb begin
      eop_mark = 2'b00;
      if (wr_num != 2'd0) begin
         eop_mark[1] = |wr_words[1].eop_code;
      end
      if (wr_num == 2'd2) begin
         eop_mark[0] = |wr_words[0].eop_code;
      end
   end

endmodule

/* regroup/word_ring_ram.sv */
module word_ring_ram (
   input  logic                           clk,
   input  regroup_pkg::tag_word_t [1:0]   wr_words,
   input  regroup_pkg::num_t              wr_num,
   input  regroup_pkg::addr_t             wr_addr,
   input  regroup_pkg::addr_t             rd_addr,
   output regroup_pkg::tag_word_t [1:0]   rd_words
);

   // word wide storage, one tagged word per entry
   regroup_pkg::tag_word_t mem [regroup_pkg::depth];

   // second word addresses, wrap past the last entry
   regroup_pkg::addr_t wr_addr_p1;
   regroup_pkg::addr_t rd_addr_p1;

   assign wr_addr_p1 = wr_addr + 1'b1;
   assign rd_addr_p1 = rd_addr + 1'b1;

   //////////////////////////////////////////////////
   // write side
   //////////////////////////////////////////////////

   // w1 lands at wr_addr
   // w0 at the next word, only for a full group
   always_ff @(posedge clk) begin
      if (wr_num != 2'd0) begin
         mem[wr_addr] <= wr_words[1];
      end
      if (wr_num == 2'd2) begin
         mem[wr_addr_p1] <= wr_words[0];
      end
   end

   //////////////////////////////////////////////////
   // read side
   //////////////////////////////////////////////////

   // always fetch a pair, scheduler decides what is used
   // a pair may straddle the ring end
   // registered, data follows rd_addr by one cycle
   always_ff @(posedge clk) begin
      rd_words[1] <= mem[rd_addr];
      rd_words[0] <= mem[rd_addr_p1];
   end

   // no read/write collision in practice
   // scheduler only sees words a cycle after their write

endmodule

/* regroup/read_scheduler.sv */
module read_scheduler (
   input  logic                     clk,
   input  logic                     arst,
   input  regroup_pkg::num_t        wr_num,
   input  regroup_pkg::addr_t       wr_addr,
   input  logic [1:0]               eop_mark,
   output regroup_pkg::addr_t       rd_addr,
   output regroup_pkg::num_t        rd_num,
   output logic                     wr_overflow
);

   // one eop flag per ring word
   logic [regroup_pkg::depth-1:0] eop_map;

   // words held, one extra bit so a full ring fits
   logic [regroup_pkg::addr_w:0] held;
   logic [regroup_pkg::addr_w:0] held_nxt;

   regroup_pkg::sched_state_t state;
   regroup_pkg::sched_state_t state_nxt;

   regroup_pkg::addr_t wr_addr_p1;
   regroup_pkg::addr_t rd_addr_p1;
   logic               first_eop;

   assign wr_addr_p1 = wr_addr + 1'b1;
   assign rd_addr_p1 = rd_addr + 1'b1;

   // eop flag of the oldest held word
   assign first_eop = eop_map[rd_addr];

   //////////////////////////////////////////////////
   // read decision
   //////////////////////////////////////////////////

   always_comb begin
      rd_num    = 2'd0;
      state_nxt = regroup_pkg::idle;
      case (state)
         regroup_pkg::hold_single: begin
            // lone word is known non-eop, wait for its partner
            if (held >= 2) begin
               rd_num = 2'd2;
            end
            else begin
               state_nxt = regroup_pkg::hold_single;
            end
         end
         default: begin
            // eop first word goes out alone
            if ((held != 0) && first_eop) begin
               rd_num = 2'd1;
            end
            else if (held >= 2) begin
               rd_num = 2'd2;
            end
            else if (held == 1) begin
               state_nxt = regroup_pkg::hold_single;
            end
         end
      endcase
   end

   // never negative, rd_num never exceeds held
   assign held_nxt = held + wr_num - rd_num;

   //////////////////////////////////////////////////
   // pointer, count and state
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         rd_addr     <= '0;
         held        <= '0;
         state       <= regroup_pkg::idle;
         wr_overflow <= 1'b0;
      end
      else begin
         rd_addr     <= rd_addr + rd_num;
         held        <= held_nxt;
         state       <= state_nxt;
         // one cycle pulse on write pointer overrun
         wr_overflow <= (held_nxt > regroup_pkg::depth);
      end
   end

   //////////////////////////////////////////////////
   // eop bitmap
   //////////////////////////////////////////////////

   // clear what is read, then load marks of new words
   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         eop_map <= '0;
      end
      else begin
         if (rd_num != 2'd0) begin
            eop_map[rd_addr] <= 1'b0;
         end
         if (rd_num == 2'd2) begin
            eop_map[rd_addr_p1] <= 1'b0;
         end
         if (wr_num != 2'd0) begin
            eop_map[wr_addr] <= eop_mark[1];
         end
         if (wr_num == 2'd2) begin
            eop_map[wr_addr_p1] <= eop_mark[0];
         end
      end
   end

endmodule

/* regroup/beat_decoder.sv */
module beat_decoder (
   input  logic                           clk,
   input  logic                           arst,
   input  regroup_pkg::tag_word_t [1:0]   rd_words,
   input  regroup_pkg::num_t              rd_num,
   output regroup_pkg::beat_t             out_beat,
   output logic                           out_valid
);

   // read count lined up with ram data
   regroup_pkg::num_t rd_num_q;

   regroup_pkg::eop_code_t code;
   regroup_pkg::beat_t     beat;
   logic                   one_word;
   logic [3:0]             valid_bytes;

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         rd_num_q <= '0;
      end
      else begin
         rd_num_q <= rd_num;
      end
   end

   //////////////////////////////////////////////////
   // eop decode
   //////////////////////////////////////////////////

   assign one_word = (rd_num_q == 2'd1);

   // last word of the beat carries the code
   assign code = one_word ? rd_words[1].eop_code : rd_words[0].eop_code;

   // 000 in the low bits stands for a full word
   assign valid_bytes = (code[2:0] == 3'd0) ? 4'd8 : {1'b0, code[2:0]};

   always_comb begin
      beat.sop   = rd_words[1].sop;
      beat.eop   = 1'b0;
      beat.error = 1'b0;
      // unused lower word is blanked on a one word beat
      beat.data  = {rd_words[1].data, one_word ? '0 : rd_words[0].data};
      if (code == 4'd0) begin
         // mid packet, empty counts the missing word
         beat.empty = one_word ? 4'd8 : 4'd0;
      end
      else if (code[3]) begin
         beat.eop   = 1'b1;
         beat.empty = 4'd8 - valid_bytes + (one_word ? 4'd8 : 4'd0);
      end
      else begin
         // 0001 and every other 0xxx code
         beat.eop   = 1'b1;
         beat.error = 1'b1;
         beat.empty = 4'd0;
      end
   end

   //////////////////////////////////////////////////
   // output register
   //////////////////////////////////////////////////

   // idle cycles carry an all zero beat
   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         out_beat  <= '0;
         out_valid <= 1'b0;
      end
      else begin
         out_valid <= (rd_num_q != 2'd0);
         if (rd_num_q != 2'd0) begin
            out_beat <= beat;
         end
         else begin
            out_beat <= '0;
         end
      end
   end

endmodule

/* hw/regroup_top.sv */
module regroup_top (
   input  logic                  clk,
   input  logic                  arst,
   input  regroup_pkg::in_grp_t  in_grp,
   output regroup_pkg::beat_t    out_beat,
   output logic                  out_valid,
   output logic                  overflow
);

   //////////////////////////////////////////////////
   // interconnect
   //////////////////////////////////////////////////

   // write path
   regroup_pkg::tag_word_t [1:0] wr_words;
   regroup_pkg::num_t            wr_num;
   regroup_pkg::addr_t           wr_addr;
   logic [1:0]                   eop_mark;

   // read path
   regroup_pkg::addr_t           rd_addr;
   regroup_pkg::num_t            rd_num;
   regroup_pkg::tag_word_t [1:0] rd_words;

   logic                         wr_overflow;

   //////////////////////////////////////////////////
   // blocks
   //////////////////////////////////////////////////

   // input register and write pointer
   regroup_wr_ctrl u_wr_ctrl (
      .clk      (clk),
      .arst     (arst),
      .in_grp   (in_grp),
      .wr_words (wr_words),
      .wr_num   (wr_num),
      .wr_addr  (wr_addr),
      .eop_mark (eop_mark)
   );

   // word addressable ring
   word_ring_ram u_ring (
      .clk      (clk),
      .wr_words (wr_words),
      .wr_num   (wr_num),
      .wr_addr  (wr_addr),
      .rd_addr  (rd_addr),
      .rd_words (rd_words)
   );

   // picks 0, 1 or 2 words per cycle on packet boundaries
   read_scheduler u_sched (
      .clk         (clk),
      .arst        (arst),
      .wr_num      (wr_num),
      .wr_addr     (wr_addr),
      .eop_mark    (eop_mark),
      .rd_addr     (rd_addr),
      .rd_num      (rd_num),
      .wr_overflow (wr_overflow)
   );

   // sop, eop, empty and error for the output bus
   beat_decoder u_decode (
      .clk       (clk),
      .arst      (arst),
      .rd_words  (rd_words),
      .rd_num    (rd_num),
      .out_beat  (out_beat),
      .out_valid (out_valid)
   );

   assign overflow = wr_overflow;

endmodule

/* dv/regroup_chk.sv */
module regroup_chk (
   input logic                clk,
   input logic                arst,
   input regroup_pkg::beat_t  out_beat,
   input logic                out_valid,
   input logic                overflow
);

   //////////////////////////////////////////////////
   // output bus properties
   //////////////////////////////////////////////////

   // every field of a strobed beat is driven
   no_x_on_beat: assert property (
      @(posedge clk) disable iff (arst)
      out_valid |-> !$isunknown(out_beat))
      else $error("output beat has unknown bits while out_valid is high");

   // write pointer never overruns the read side
   no_overflow: assert property (
      @(posedge clk) disable iff (arst)
      !overflow)
      else $error("ring overflow flag rose");

   // no beats while the block is held in reset
   quiet_in_reset: assert property (
      @(posedge clk)
      arst |-> !out_valid)
      else $error("out_valid high during reset");

endmodule

bind regroup_top regroup_chk chk0 (
   .clk       (clk),
   .arst      (arst),
   .out_beat  (out_beat),
   .out_valid (out_valid),
   .overflow  (overflow)
);

/* dv/regroup_tb.sv */
module regroup_tb;

   localparam int reset_len   = 10;
   // words in flight before the driver pauses, well under the ring depth
   localparam int backlog_max = 40;

   // expected beat plus how many ring words it used
   typedef struct packed {
      regroup_pkg::beat_t beat;
      regroup_pkg::num_t  nwords;
   } expect_t;

   logic                 clk = 1'b0;
   logic                 arst;
   regroup_pkg::in_grp_t in_grp;
   regroup_pkg::beat_t   out_beat;
   logic                 out_valid;
   logic                 overflow;

   integer seed = 32'h69fe_cdd5;

   regroup_pkg::tag_word_t gen_q[$];
   expect_t                exp_q[$];

   string test_name = "reset";
   int    words_in    = 0;
   int    words_out   = 0;
   int    in_cycles   = 0;

   regroup_top dut0 (
      .clk       (clk),
      .arst      (arst),
      .in_grp    (in_grp),
      .out_beat  (out_beat),
      .out_valid (out_valid),
      .overflow  (overflow)
   );

   always #10 clk = ~clk;

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   task automatic report_fail();
      $display("=== FAIL ===");
      $fatal(1, "regroup_tb stopped at the first error");
   endtask

   function automatic int rand_range(input int lo, input int hi);
      return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   // one packet of nbytes, err_code nonzero marks its last word as errored
   task automatic add_packet(input int nbytes, input regroup_pkg::eop_code_t err_code);
      int                     nwords;
      regroup_pkg::tag_word_t w;
      nwords = (nbytes + 7) / 8;
      for (int i = 0; i < nwords; i++) begin
         w.sop  = (i == 0);
         w.data = {$random(seed), $random(seed)};
         if (i != nwords - 1) begin
            w.eop_code = 4'd0;
         end
         else if (err_code != 4'd0) begin
            w.eop_code = err_code;
         end
         else begin
            // 8 valid bytes wraps to 000
            w.eop_code = {1'b1, 3'(nbytes - 8 * (nwords - 1))};
         end
         gen_q.push_back(w);
      end
   endtask

   //////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////

   function automatic expect_t model_beat(input regroup_pkg::tag_word_t first,
                                          input regroup_pkg::tag_word_t second,
                                          input logic two);
      expect_t                e;
      regroup_pkg::eop_code_t code;
      int                     valid;
      // last word of the beat carries the code
      code          = two ? second.eop_code : first.eop_code;
      e.nwords      = two ? 2'd2 : 2'd1;
      e.beat.sop    = first.sop;
      e.beat.data   = {first.data, two ? second.data : 64'd0};
      e.beat.eop    = 1'b0;
      e.beat.error  = 1'b0;
      if (code == 4'd0) begin
         e.beat.empty = two ? 4'd0 : 4'd8;
      end
      else if (!code[3]) begin
         e.beat.eop   = 1'b1;
         e.beat.error = 1'b1;
         e.beat.empty = 4'd0;
      end
      else begin
         valid = (code[2:0] == 3'd0) ? 8 : int'(code[2:0]);
         if (two) begin
            valid = valid + 8;
         end
         e.beat.eop   = 1'b1;
         e.beat.empty = 4'(16 - valid);
      end
      return e;
   endfunction

   // eop word goes alone, otherwise pair it with the next word
   function automatic void build_expected();
      int i;
      i = 0;
      while (i < gen_q.size()) begin
         if (gen_q[i].eop_code != 4'd0) begin
            exp_q.push_back(model_beat(gen_q[i], '0, 1'b0));
            i = i + 1;
         end
         else if (i + 1 < gen_q.size()) begin
            exp_q.push_back(model_beat(gen_q[i], gen_q[i + 1], 1'b1));
            i = i + 2;
         end
         else begin
            // trailing lone word would stay in the ring
            i = gen_q.size();
         end
      end
   endfunction

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////

   // sparse picks 0, 1 or 2 words a cycle, otherwise full rate
   task automatic drive_words(input logic sparse);
      int                   n;
      regroup_pkg::in_grp_t g;
      while (gen_q.size() != 0) begin
         @(posedge clk);
         #1;
         g = '0;
         n = sparse ? rand_range(0, 2) : 2;
         if (words_in - words_out > backlog_max) begin
            n = 0;
         end
         if (n > gen_q.size()) begin
            n = gen_q.size();
         end
         if (n >= 1) begin
            g.w1 = gen_q.pop_front();
         end
         if (n == 2) begin
            g.w0 = gen_q.pop_front();
         end
         g.num = regroup_pkg::num_t'(n);
         if (n != 0) begin
            in_cycles = in_cycles + 1;
         end
         words_in = words_in + n;
         in_grp   = g;
      end
      @(posedge clk);
      #1;
      in_grp = '0;
   endtask

   task automatic run_test(input string name, input logic sparse);
      test_name = name;
      build_expected();
      drive_words(sparse);
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
   endtask

   //////////////////////////////////////////////////
   // comparison
   //////////////////////////////////////////////////

   task automatic compare_value(input string field, input logic [127:0] expv,
                                input logic [127:0] actv);
      assert (expv == actv) else begin
         $display("Mismatch test=%s field=%s expected=%0h actual=%0h",
                  test_name, field, expv, actv);
         report_fail();
      end
   endtask

   // outputs settle after the rising edge, sample on the falling one
   always @(negedge clk) begin : compare_beats
      expect_t      e;
      logic [127:0] mask;
      if (!arst && out_valid) begin
         assert (exp_q.size() != 0) else begin
            $display("unexpected output beat in test %s", test_name);
            report_fail();
         end
         e = exp_q.pop_front();
         compare_value("sop", 128'(e.beat.sop), 128'(out_beat.sop));
         compare_value("eop", 128'(e.beat.eop), 128'(out_beat.eop));
         compare_value("error", 128'(e.beat.error), 128'(out_beat.error));
         compare_value("empty", 128'(e.beat.empty), 128'(out_beat.empty));
         // only the upper 16 - empty bytes carry data
         mask = '0;
         for (int b = 0; b < 16; b++) begin
            if (b >= int'(e.beat.empty)) begin
               mask[8*b +: 8] = 8'hff;
            end
         end
         compare_value("data", e.beat.data & mask, out_beat.data & mask);
         words_out  = words_out + int'(e.nwords);
      end
   end

   always @(negedge clk) begin : watch_flags
      assert (!overflow) else begin
         $display("ring overflow flag rose in test %s", test_name);
         report_fail();
      end
      if (arst) begin
         assert (!out_valid) else begin
            $display("out_valid went high during reset");
            report_fail();
         end
      end
   end

   // limit scales with the input cycles actually driven
   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles <= 4 * in_cycles + 200 + reset_len) begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      $display("timeout in test %s after %0d cycles, %0d input cycles",
               test_name, cycles, in_cycles);
      report_fail();
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin : main_flow
      regroup_pkg::eop_code_t err;
      arst   = 1'b1;
      in_grp = '0;
      repeat (reset_len) @(posedge clk);
      #1;
      arst = 1'b0;

      // random lengths at two words a cycle
      for (int k = 0; k < 60; k++) begin
         add_packet(rand_range(1, 200), 4'd0);
      end
      run_test("full_rate", 1'b0);

      // single word packets back to back
      for (int k = 0; k < 80; k++) begin
         add_packet(rand_range(1, 8), 4'd0);
      end
      run_test("single_word", 1'b0);

      // gaps and lone words waiting for a partner
      for (int k = 0; k < 60; k++) begin
         add_packet(rand_range(1, 64), 4'd0);
      end
      run_test("sparse", 1'b1);

      // every other packet ends in an error code
      for (int k = 0; k < 40; k++) begin
         err = (k % 3 == 0) ? 4'b0001 : regroup_pkg::eop_code_t'(rand_range(2, 7));
         add_packet(rand_range(1, 40), (k % 2 == 1) ? err : 4'd0);
      end
      run_test("error_eop", 1'b0);

      // many ring wraps
      // single word groups shift the write pointer so pairs straddle the last entry
      for (int k = 0; k < 150; k++) begin
         add_packet(rand_range(1, 200), 4'd0);
      end
      run_test("ring_wrap", 1'b1);

      $display("=== PASS ===");
      $finish;
   end

endmodule

/* src.f */
common/regroup_pkg.sv
regroup/regroup_wr_ctrl.sv
regroup/word_ring_ram.sv
regroup/read_scheduler.sv
regroup/beat_decoder.sv
hw/regroup_top.sv
dv/regroup_chk.sv
dv/regroup_tb.sv

/* run.sh */
#!/bin/sh
# build and run the regroup testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --assert -Wno-fatal --top-module regroup_tb \
   -f src.f -o regroup_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status, see build.log"
   exit 1
fi

./obj_dir/regroup_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status, see sim.log"
fi

if grep -qx "=== PASS ===" sim.log; then
   echo "regroup simulation passed"
   exit 0
else
   echo "regroup simulation failed, see sim.log"
   exit 1
fi
